/* source/rv_isa_pkg.sv */
/*
 * RV32I encoding constants: opcodes, funct3 and funct7 values,
 * and the fixed system instruction words
 */
package rv_isa_pkg;

	// major opcodes, inst[6:0]
	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
	localparam logic [6:0] OPC_JAL    = 7'b1101111;
	localparam logic [6:0] OPC_JALR   = 7'b1100111;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_LOAD   = 7'b0000011;
	localparam logic [6:0] OPC_STORE  = 7'b0100011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

	// jalr only defines funct3 zero
	localparam logic [2:0] F3_JALR = 3'b000;

	// branches, 010 and 011 are reserved
	localparam logic [2:0] F3_BEQ  = 3'b000;
	localparam logic [2:0] F3_BNE  = 3'b001;
	localparam logic [2:0] F3_BLT  = 3'b100;
	localparam logic [2:0] F3_BGE  = 3'b101;
	localparam logic [2:0] F3_BLTU = 3'b110;
	localparam logic [2:0] F3_BGEU = 3'b111;

	// loads
	localparam logic [2:0] F3_LB  = 3'b000;
	localparam logic [2:0] F3_LH  = 3'b001;
	localparam logic [2:0] F3_LW  = 3'b010;
	localparam logic [2:0] F3_LBU = 3'b100;
	localparam logic [2:0] F3_LHU = 3'b101;

	// stores
	localparam logic [2:0] F3_SB = 3'b000;
	localparam logic [2:0] F3_SH = 3'b001;
	localparam logic [2:0] F3_SW = 3'b010;

	// op-imm, also shared by op for the shift and add slots
	localparam logic [2:0] F3_ADDI  = 3'b000;
	localparam logic [2:0] F3_SLLI  = 3'b001;
	localparam logic [2:0] F3_SRLI  = 3'b101;

	// csr access
	localparam logic [2:0] F3_CSRRW = 3'b001;
	localparam logic [2:0] F3_CSRRS = 3'b010;

	// funct7 for shifts and the register ops
	localparam logic [6:0] F7_BASE = 7'b0000000;
	localparam logic [6:0] F7_ALT  = 7'b0100000;

	// whole system words
	localparam logic [31:0] INST_ECALL  = 32'h0000_0073;
	localparam logic [31:0] INST_EBREAK = 32'h0010_0073;
	localparam logic [31:0] INST_MRET   = 32'h3020_0073;

endpackage

/* source/fetch_pkg.sv */
/*
 * fetch stage types: redirect bundle, wishbone request and response,
 * fetch packet, reset pc and pc step
 */
package fetch_pkg;

	typedef logic [31:0] word_t;

	// pc after reset
	localparam word_t RESET_PC = 32'h8000_0000;

	// one instruction word per fetch
	localparam word_t PC_STEP = 32'd4;

	// redirect sources from execute, each valid is a single cycle pulse
	typedef struct packed {
		logic  csr_valid;
		word_t csr_target;
		logic  jmp_valid;
		word_t jmp_target;
		logic  branch_valid;
		word_t branch_target;
	} redirect_t;

	// wishbone classic master outputs, read only
	typedef struct packed {
		logic  cyc;
		logic  stb;
		word_t adr;
	} wb_req_t;

	// wishbone classic slave outputs
	typedef struct packed {
		word_t dat;
		logic  ack;
		logic  err;
	} wb_rsp_t;

	// packet handed to decode
	typedef struct packed {
		word_t pc;
		word_t inst;
		logic  illegal;
		logic  bus_err;
	} fetch_packet_t;

endpackage

/* source/pc_sequencer.sv */
/*
 * program counter with csr > jmp > branch redirect priority,
 * sequential advance and a registered flush pulse
 */
`timescale 1ns/1ns

module pc_sequencer
	import fetch_pkg::*;
(
	input  logic      clock,
	input  logic      reset,
	input  redirect_t redirect_i,
	input  logic      advance_i,
	output word_t     pc_o,
	output logic      flush_o
);

	logic  any_redirect;
	word_t redirect_pc;

	assign any_redirect = redirect_i.csr_valid | redirect_i.jmp_valid |
		redirect_i.branch_valid;

	// fixed priority among simultaneous redirects
	always_comb begin
		if (redirect_i.csr_valid) begin
			redirect_pc = redirect_i.csr_target;
		end else if (redirect_i.jmp_valid) begin
			redirect_pc = redirect_i.jmp_target;
		end else begin
			redirect_pc = redirect_i.branch_target;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			pc_o    <= RESET_PC;
			flush_o <= 1'b0;
		end else begin
			// flush lines up with the first cycle of the new pc
			flush_o <= any_redirect;
			if (any_redirect) begin
				pc_o <= redirect_pc;
			end else if (advance_i) begin
				pc_o <= pc_o + PC_STEP;
			end
		end
	end

endmodule

/* source/wb_fetch_master.sv */
/*
 * wishbone classic read master, one instruction word per bus cycle
 */
`timescale 1ns/1ns

module wb_fetch_master
	import fetch_pkg::*;
(
	input  logic    clock,
	input  logic    reset,
	input  logic    start_i,
	input  word_t   addr_i,
	output wb_req_t wb_req_o,
	input  wb_rsp_t wb_rsp_i,
	output logic    done_o,
	output word_t   data_o,
	output logic    err_o
);

	logic  busy;
	logic  finish;
	word_t adr_q;

	// cycle ends on either ack or err
	assign finish = busy & (wb_rsp_i.ack | wb_rsp_i.err);

	always_ff @(posedge clock) begin
		if (reset) begin
			busy <= 1'b0;
		end else if (finish) begin
			busy <= 1'b0;
		end else if (!busy && start_i) begin
			busy <= 1'b1;
		end
	end

	// address held for the whole cycle
	always_ff @(posedge clock) begin
		if (!busy && start_i) begin
			adr_q <= addr_i;
		end
	end

	assign wb_req_o = '{
		cyc: busy,
		stb: busy,
		adr: adr_q
	};

	// result is valid only in the ack/err cycle
	assign done_o = finish;
	assign data_o = wb_rsp_i.dat;
	assign err_o  = busy & wb_rsp_i.err;

endmodule

/* source/inst_screen.sv */
/*
 * combinational screen of one word against the supported rv32i subset
 */
`timescale 1ns/1ns

module inst_screen
	import fetch_pkg::*;
	import rv_isa_pkg::*;
(
	input  word_t inst_i,
	output logic  illegal_o
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic       legal;

	assign opcode = inst_i[6:0];
	assign funct3 = inst_i[14:12];
	assign funct7 = inst_i[31:25];

	always_comb begin
		legal = 1'b0;
		case (opcode)
			OPC_LUI, OPC_AUIPC, OPC_JAL: begin
				legal = 1'b1;
			end
			OPC_JALR: begin
				legal = (funct3 == F3_JALR);
			end
			OPC_BRANCH: begin
				legal = (funct3 == F3_BEQ) || (funct3 == F3_BNE) ||
					(funct3 == F3_BLT) || (funct3 == F3_BGE) ||
					(funct3 == F3_BLTU) || (funct3 == F3_BGEU);
			end
			OPC_LOAD: begin
				legal = (funct3 == F3_LB) || (funct3 == F3_LH) ||
					(funct3 == F3_LW) || (funct3 == F3_LBU) ||
					(funct3 == F3_LHU);
			end
			OPC_STORE: begin
				legal = (funct3 == F3_SB) || (funct3 == F3_SH) || (funct3 == F3_SW);
			end
			OPC_OP_IMM: begin
				// only the shifts constrain funct7
				if (funct3 == F3_SLLI) begin
					legal = (funct7 == F7_BASE);
				end else if (funct3 == F3_SRLI) begin
					legal = (funct7 == F7_BASE) || (funct7 == F7_ALT);
				end else begin
					legal = 1'b1;
				end
			end
			OPC_OP: begin
				// alt funct7 is sub and sra only
				legal = (funct7 == F7_BASE) ||
					((funct7 == F7_ALT) && ((funct3 == F3_ADDI) || (funct3 == F3_SRLI)));
			end
			OPC_SYSTEM: begin
				legal = (inst_i == INST_ECALL) || (inst_i == INST_EBREAK) ||
					(inst_i == INST_MRET) ||
					(funct3 == F3_CSRRW) || (funct3 == F3_CSRRS);
			end
			default: begin
				legal = 1'b0;
			end
		endcase
	end

	assign illegal_o = ~legal;

endmodule

/* source/fetch_ctrl.sv */
/*
 * fetch FSM: issue a read, wait for the bus, hold the packet for decode,
 * squash results that a redirect made stale
 */
`timescale 1ns/1ns

module fetch_ctrl
	import fetch_pkg::*;
(
	input  logic          clock,
	input  logic          reset,
	input  word_t         pc_i,
	input  logic          flush_i,
	output logic          advance_o,
	output logic          start_o,
	output word_t         fetch_addr_o,
	input  logic          done_i,
	input  word_t         data_i,
	input  logic          err_i,
	input  logic          illegal_i,
	output fetch_packet_t packet_o,
	output logic          valid_o,
	input  logic          ready_i
);

	typedef enum logic [1:0] {
		ST_ISSUE,
		ST_WAIT,
		ST_HOLD
	} state_t;

	state_t        state;
	logic          squash;
	logic          discard;
	fetch_packet_t packet_q;

	// a flush seen now or earlier in this bus cycle kills the result
	assign discard = squash | flush_i;

	assign start_o      = (state == ST_ISSUE);
	assign fetch_addr_o = pc_i;

	// held packet is dropped in the flush cycle
	assign valid_o   = (state == ST_HOLD) & ~flush_i;
	assign advance_o = valid_o & ready_i;
	assign packet_o  = packet_q;

	always_ff @(posedge clock) begin
		if (reset) begin
			state  <= ST_ISSUE;
			squash <= 1'b0;
		end else begin
			case (state)
				ST_ISSUE: begin
					state  <= ST_WAIT;
					squash <= 1'b0;
				end
				ST_WAIT: begin
					if (done_i) begin
						state  <= discard ? ST_ISSUE : ST_HOLD;
						squash <= 1'b0;
					end else if (flush_i) begin
						squash <= 1'b1;
					end
				end
				ST_HOLD: begin
					// leave on transfer or on flush
					if (ready_i || flush_i) begin
						state <= ST_ISSUE;
					end
				end
				default: begin
					state <= ST_ISSUE;
				end
			endcase
		end
	end

	// bus error reports a zero word that is not flagged illegal
	always_ff @(posedge clock) begin
		if ((state == ST_WAIT) && done_i && !discard) begin
			packet_q <= '{
				pc:      pc_i,
				inst:    err_i ? '0 : data_i,
				illegal: illegal_i & ~err_i,
				bus_err: err_i
			};
		end
	end

endmodule

/* source/if_top.sv */
/*
 * instruction fetch stage top: pc sequencer, bus master, screen, control
 */
`timescale 1ns/1ns

module if_top
	import fetch_pkg::*;
(
	input  logic          clock,
	input  logic          reset,
	output wb_req_t       wb_req_o,
	input  wb_rsp_t       wb_rsp_i,
	input  redirect_t     redirect_i,
	output fetch_packet_t packet_o,
	output logic          valid_o,
	input  logic          ready_i
);

	word_t pc;
	logic  flush;
	logic  advance;
	logic  start;
	word_t fetch_addr;
	logic  done;
	word_t data;
	logic  err;
	logic  illegal;

	pc_sequencer u_pc_sequencer (
		.clock      (clock),
		.reset      (reset),
		.redirect_i (redirect_i),
		.advance_i  (advance),
		.pc_o       (pc),
		.flush_o    (flush)
	);

	wb_fetch_master u_wb_fetch_master (
		.clock    (clock),
		.reset    (reset),
		.start_i  (start),
		.addr_i   (fetch_addr),
		.wb_req_o (wb_req_o),
		.wb_rsp_i (wb_rsp_i),
		.done_o   (done),
		.data_o   (data),
		.err_o    (err)
	);

	inst_screen u_inst_screen (
		.inst_i    (data),
		.illegal_o (illegal)
	);

	fetch_ctrl u_fetch_ctrl (
		.clock        (clock),
		.reset        (reset),
		.pc_i         (pc),
		.flush_i      (flush),
		.advance_o    (advance),
		.start_o      (start),
		.fetch_addr_o (fetch_addr),
		.done_i       (done),
		.data_i       (data),
		.err_i        (err),
		.illegal_i    (illegal),
		.packet_o     (packet_o),
		.valid_o      (valid_o),
		.ready_i      (ready_i)
	);

endmodule

/* testbench/if_top_chk.sv */
/*
 * concurrent checks on the wishbone request and the decode handshake,
 * bound into if_top
 */
`timescale 1ns/1ns

module if_top_chk
	import fetch_pkg::*;
(
	input logic          clock,
	input logic          reset,
	input wb_req_t       wb_req_o,
	input wb_rsp_t       wb_rsp_i,
	input fetch_packet_t packet_o,
	input logic          valid_o,
	input logic          ready_i
);

	// open request keeps cyc, stb and adr until the slave answers
	request_held: assert property (@(posedge clock) disable iff (reset)
		(wb_req_o.stb && !wb_rsp_i.ack && !wb_rsp_i.err) |=>
		(wb_req_o.cyc && wb_req_o.stb && $stable(wb_req_o.adr)))
		else $error("wishbone request dropped or changed before ack or err");

	// decode sees a steady packet while it stalls
	packet_stable: assert property (@(posedge clock) disable iff (reset)
		(valid_o && !ready_i) |=> $stable(packet_o))
		else $error("held packet changed under back-pressure");

	// no bus cycle out of reset
	cyc_low_in_reset: assert property (@(posedge clock)
		reset |=> !wb_req_o.cyc)
		else $error("wishbone cyc high while reset is asserted");

endmodule

bind if_top if_top_chk chk_i (
	.clock    (clock),
	.reset    (reset),
	.wb_req_o (wb_req_o),
	.wb_rsp_i (wb_rsp_i),
	.packet_o (packet_o),
	.valid_o  (valid_o),
	.ready_i  (ready_i)
);

/* testbench/tb_top.sv */
/*
 * fetch stage testbench: clock, reset, wishbone memory model,
 * directed tests, compare tasks and timeout
 */
`timescale 1ns/1ns

module tb_top
	import fetch_pkg::*;
	import rv_isa_pkg::*;
();

	localparam int TOTAL_FETCHES  = 48;
	localparam int TIMEOUT_CYCLES = 40 * TOTAL_FETCHES + 200;

	logic          clock;
	logic          reset;
	wb_req_t       wb_req;
	wb_rsp_t       wb_rsp;
	redirect_t     redirect;
	fetch_packet_t packet;
	logic          valid;
	logic          ready;

	word_t mem [0:255];
	word_t err_addrs [$];
	int    seed = 32'hfce5ccf6;
	bit    rand_wait;
	bit    rand_ready;
	bit    ready_want;
	int    fixed_wait;
	bit    in_cycle;
	int    wait_left;
	int    cycles;
	int    errors;
	int    tests_run;
	int    tests_failed;

	if_top dut_i (
		.clock      (clock),
		.reset      (reset),
		.wb_req_o   (wb_req),
		.wb_rsp_i   (wb_rsp),
		.redirect_i (redirect),
		.packet_o   (packet),
		.valid_o    (valid),
		.ready_i    (ready)
	);

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	// legal addi whose immediate follows the whole address
	function automatic word_t fill_word(word_t a);
		return {a[13:2] ^ a[31:20], 5'd0, 3'b000, 5'd1, 7'b0010011};
	endfunction

	function automatic bit is_err_addr(word_t a);
		foreach (err_addrs[i]) begin
			if (err_addrs[i] == a) begin
				return 1'b1;
			end
		end
		return 1'b0;
	endfunction

	function automatic int pick_wait();
		int rnd;
		rnd = $random(seed);
		if (rand_wait) begin
			return int'(rnd[2:0]) % 5;
		end
		return fixed_wait;
	endfunction

	// wishbone slave, ack or err after the wait count
	always @(posedge clock) begin
		if (reset) begin
			wb_rsp <= '0;
			in_cycle = 1'b0;
		end else if (wb_rsp.ack || wb_rsp.err) begin
			wb_rsp <= '0;
			in_cycle = 1'b0;
		end else if (wb_req.cyc && wb_req.stb) begin
			if (!in_cycle) begin
				in_cycle = 1'b1;
				wait_left = pick_wait();
			end
			if (wait_left == 0) begin
				wb_rsp.dat <= mem[wb_req.adr[9:2]];
				wb_rsp.ack <= !is_err_addr(wb_req.adr);
				wb_rsp.err <= is_err_addr(wb_req.adr);
			end else begin
				wait_left = wait_left - 1;
			end
		end
	end

	// decode side ready, random gaps on request
	always @(posedge clock) begin
		int rnd;
		rnd = $random(seed);
		ready <= rand_ready ? (rnd[1:0] != 2'b00) : ready_want;
	end

	always @(posedge clock) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("timeout: no result after %0d cycles", cycles);
			$display("TB FAILED");
			$finish;
		end
	end

	task automatic init_memory();
		for (int i = 0; i < 256; i++) begin
			mem[i] = fill_word(RESET_PC + word_t'(i * 4));
		end
		err_addrs.delete();
	endtask

	// modes change away from the rising edge
	task automatic set_modes(bit rw, bit rr, bit rdy, int fw);
		@(negedge clock);
		rand_wait  = rw;
		rand_ready = rr;
		ready_want = rdy;
		fixed_wait = fw;
	endtask

	task automatic apply_reset();
		@(posedge clock);
		reset    <= 1'b1;
		redirect <= '0;
		repeat (2) @(posedge clock);
		reset <= 1'b0;
	endtask

	task automatic drive_redirect(redirect_t r);
		@(posedge clock);
		redirect <= r;
		@(posedge clock);
		redirect <= '0;
	endtask

	task automatic receive_packet(output fetch_packet_t p);
		do begin
			@(negedge clock);
		end while (!(valid && ready));
		p = packet;
		@(posedge clock);
	endtask

	function automatic fetch_packet_t make_expected(word_t pc, logic illegal);
		return '{pc: pc, inst: mem[pc[9:2]], illegal: illegal, bus_err: 1'b0};
	endfunction

	task automatic check_packet(string what, fetch_packet_t got, fetch_packet_t exp);
		if (got.pc !== exp.pc) begin
			$display("** Error: %s packet.pc expected %h got %h", what, exp.pc, got.pc);
			errors++;
		end
		if (got.inst !== exp.inst) begin
			$display("** Error: %s packet.inst expected %h got %h", what, exp.inst, got.inst);
			errors++;
		end
		if (got.illegal !== exp.illegal) begin
			$display("** Error: %s packet.illegal expected %h got %h", what, exp.illegal,
				got.illegal);
			errors++;
		end
		if (got.bus_err !== exp.bus_err) begin
			$display("** Error: %s packet.bus_err expected %h got %h", what, exp.bus_err,
				got.bus_err);
			errors++;
		end
	endtask

	task automatic check_pc(string what, word_t got, word_t exp);
		if (got !== exp) begin
			$display("** Error: %s wb_req.adr expected %h got %h", what, exp, got);
			errors++;
		end
	endtask

	// address of the next bus cycle, once any stale cycle has closed
	task automatic check_next_adr(string what, word_t exp);
		do begin
			@(negedge clock);
		end while (wb_req.cyc);
		do begin
			@(negedge clock);
		end while (!wb_req.cyc);
		check_pc(what, wb_req.adr, exp);
	endtask

	task automatic report_test(string name, int errors_before);
		tests_run++;
		if (errors == errors_before) begin
			$display("test %s: ok", name);
		end else begin
			tests_failed++;
			$display("test %s: %0d errors", name, errors - errors_before);
		end
	endtask

	task automatic run_sequence(string name, int count);
		fetch_packet_t p;
		for (int k = 0; k < count; k++) begin
			receive_packet(p);
			check_packet(name, p, make_expected(RESET_PC + word_t'(k * 4), 1'b0));
		end
	endtask

	task automatic test_sequential();
		int e0 = errors;
		init_memory();
		set_modes(1'b0, 1'b0, 1'b1, 0);
		apply_reset();
		run_sequence("sequential", 8);
		report_test("sequential", e0);
	endtask

	task automatic test_screen();
		int            e0 = errors;
		word_t         words [18];
		bit            bad [18];
		fetch_packet_t p;
		words = '{32'h0010_0093, 32'h0010_9093, 32'h4010_d093, 32'h0000_a083,
			32'h0011_2023, 32'h0000_0063, 32'h3402_9073, INST_ECALL, INST_EBREAK,
			INST_MRET, 32'h4000_0033, 32'h4010_9093, 32'h0000_000f, 32'h0000_0000,
			32'h0000_b083, 32'h0000_2063, 32'h4000_1033, 32'hffff_ffff};
		bad = '{0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1, 1, 1, 1, 1, 1, 1};
		init_memory();
		for (int i = 0; i < 18; i++) begin
			mem[i] = words[i];
		end
		set_modes(1'b0, 1'b0, 1'b1, 0);
		apply_reset();
		for (int k = 0; k < 18; k++) begin
			receive_packet(p);
			check_packet("screen", p, make_expected(RESET_PC + word_t'(k * 4), bad[k]));
		end
		report_test("screen", e0);
	endtask

	task automatic test_random_stalls();
		int e0 = errors;
		init_memory();
		set_modes(1'b1, 1'b1, 1'b1, 0);
		apply_reset();
		run_sequence("random stalls", 12);
		set_modes(1'b0, 1'b0, 1'b1, 0);
		report_test("random stalls", e0);
	endtask

	// redirect while the first packet waits on a stalled decode
	task automatic redirect_case(string name, redirect_t r, word_t target);
		fetch_packet_t p;
		init_memory();
		set_modes(1'b0, 1'b0, 1'b0, 0);
		apply_reset();
		do begin
			@(negedge clock);
		end while (!valid);
		drive_redirect(r);
		@(negedge clock);
		ready_want = 1'b1;
		check_next_adr(name, target);
		receive_packet(p);
		check_packet(name, p, make_expected(target, 1'b0));
		receive_packet(p);
		check_packet(name, p, make_expected(target + PC_STEP, 1'b0));
	endtask

	task automatic test_redirect_priority();
		int        e0 = errors;
		redirect_t r;
		r = '{csr_valid: 1'b1, csr_target: RESET_PC + 32'h100,
			jmp_valid: 1'b1, jmp_target: RESET_PC + 32'h200,
			branch_valid: 1'b1, branch_target: RESET_PC + 32'h300};
		redirect_case("priority csr", r, RESET_PC + 32'h100);
		r.csr_valid = 1'b0;
		redirect_case("priority jmp", r, RESET_PC + 32'h200);
		report_test("redirect priority", e0);
	endtask

	task automatic test_bus_error();
		int            e0 = errors;
		fetch_packet_t p;
		fetch_packet_t exp;
		init_memory();
		// illegal nonzero word behind the error address
		mem[2] = 32'hffff_ffff;
		err_addrs.push_back(RESET_PC + 32'h8);
		set_modes(1'b0, 1'b0, 1'b1, 0);
		apply_reset();
		for (int k = 0; k < 4; k++) begin
			receive_packet(p);
			exp = make_expected(RESET_PC + word_t'(k * 4), 1'b0);
			if (k == 2) begin
				exp.inst    = '0;
				exp.bus_err = 1'b1;
			end
			check_packet("bus error", p, exp);
		end
		err_addrs.delete();
		report_test("bus error", e0);
	endtask

	task automatic test_redirect_in_wait();
		int            e0 = errors;
		redirect_t     r;
		fetch_packet_t p;
		word_t         target;
		target = RESET_PC + 32'h180;
		r = '0;
		r.jmp_valid  = 1'b1;
		r.jmp_target = target;
		init_memory();
		set_modes(1'b0, 1'b0, 1'b1, 20);
		apply_reset();
		do begin
			@(negedge clock);
		end while (!wb_req.cyc);
		repeat (3) @(negedge clock);
		drive_redirect(r);
		@(negedge clock);
		fixed_wait = 0;
		check_next_adr("redirect in wait", target);
		receive_packet(p);
		check_packet("redirect in wait", p, make_expected(target, 1'b0));
		receive_packet(p);
		check_packet("redirect in wait", p, make_expected(target + PC_STEP, 1'b0));
		report_test("redirect in wait", e0);
	endtask

	initial begin
		reset      <= 1'b1;
		redirect   <= '0;
		wb_rsp     <= '0;
		ready      <= 1'b0;
		rand_wait  = 1'b0;
		rand_ready = 1'b0;
		ready_want = 1'b0;
		fixed_wait = 0;
		in_cycle   = 1'b0;
		wait_left  = 0;
		cycles     <= 0;
		errors     = 0;
		tests_run    = 0;
		tests_failed = 0;
		test_sequential();
		test_screen();
		test_random_stalls();
		test_redirect_priority();
		test_bus_error();
		test_redirect_in_wait();
		$display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

/* tb.f */
source/rv_isa_pkg.sv
source/fetch_pkg.sv
source/pc_sequencer.sv
source/wb_fetch_master.sv
source/inst_screen.sv
source/fetch_ctrl.sv
source/if_top.sv
testbench/if_top_chk.sv
testbench/tb_top.sv

/* run_sim.sh */
#!/bin/sh
# build and run the fetch stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module tb_top -o tb_sim

out=$(./obj_dir/tb_sim)
echo "$out"

# pass only when the testbench reported it
echo "$out" | grep -q "TB PASSED"
